// File: Bender.yml
package:
  name: mem_endpoint

sources:
  - rtl/mem_pkg.sv
  - rtl/mem_byte_array.sv
  - rtl/mem_req_stage.sv
  - rtl/mem_access_stage.sv
  - rtl/mem_resp_buffer.sv
  - rtl/mem_endpoint_top.sv
  - target: test
    files:
      - tests/mem_endpoint_tb.sv

// File: rtl/mem_access_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_stage #(
  parameter int addr_width_p = 6
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             stage_valid_i,
  output logic                             stage_ready_o,
  input  mem_pkg::mem_req_t                stage_req_i,
  input  logic                             stage_err_i,
  output logic                             rd_en_o,
  output logic [addr_width_p-1:0]          rd_addr_o,
  output logic                             wr_en_o,
  output logic [addr_width_p-1:0]          wr_addr_o,
  output logic [mem_pkg::data_width_c-1:0] wr_data_o,
  output logic [mem_pkg::mask_width_c-1:0] wr_mask_o,
  input  logic [mem_pkg::data_width_c-1:0] rd_data_i,
  input  logic [1:0]                       free_slots_i,
  output logic                             push_valid_o,
  output mem_pkg::mem_resp_t               push_resp_o
);
  import mem_pkg::*;

  logic                   issue;
  logic                   is_read;
  logic                   hold_valid_q;
  mem_op_e                hold_op_q;
  mem_status_e            hold_status_q;
  logic [tag_width_c-1:0] hold_tag_q;

  // Held item still needs its own slot in the buffer.
  assign stage_ready_o = free_slots_i > {1'b0, hold_valid_q};
  assign issue         = stage_valid_i & stage_ready_o;
  assign is_read       = stage_req_i.op == mem_op_read;

  assign rd_en_o   = issue & is_read & ~stage_err_i;
  assign rd_addr_o = stage_req_i.addr[addr_width_p-1:0];
  assign wr_en_o   = issue & ~is_read & ~stage_err_i;
  assign wr_addr_o = stage_req_i.addr[addr_width_p-1:0];
  assign wr_data_o = stage_req_i.payload.wr.data;
  assign wr_mask_o = stage_req_i.payload.wr.mask;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
    end else begin
      hold_valid_q <= issue;
    end
  end

  // Record of the item whose array access is under way.
  always_ff @(posedge clk_i) begin
    if (issue) begin
      hold_op_q     <= stage_req_i.op;
      hold_status_q <= stage_err_i ? mem_status_err : mem_status_ok;
      hold_tag_q    <= (is_read & ~stage_err_i) ? stage_req_i.payload.rd.tag : '0;
    end
  end

  always_comb begin
    push_resp_o.op     = hold_op_q;
    push_resp_o.status = hold_status_q;
    push_resp_o.tag    = hold_tag_q;
    push_resp_o.data   = '0;
    if (hold_op_q == mem_op_read && hold_status_q == mem_status_ok) begin
      push_resp_o.data = rd_data_i;  // Array output registered last edge.
    end
  end

  assign push_valid_o = hold_valid_q;

endmodule

`default_nettype wire

// File: rtl/mem_byte_array.sv
`timescale 1ns/1ps
`default_nettype none

module mem_byte_array #(
  parameter int els_p        = 48,
  parameter int addr_width_p = 6
) (
  input  logic                             clk_i,
  input  logic                             rd_en_i,
  input  logic [addr_width_p-1:0]          rd_addr_i,
  output logic [mem_pkg::data_width_c-1:0] rd_data_o,
  input  logic                             wr_en_i,
  input  logic [addr_width_p-1:0]          wr_addr_i,
  input  logic [mem_pkg::data_width_c-1:0] wr_data_i,
  input  logic [mem_pkg::mask_width_c-1:0] wr_mask_i
);
  import mem_pkg::*;

  logic [data_width_c-1:0] mem_q [els_p];

  // Read data holds when no read is issued.
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < mask_width_c; b++) begin
      if (wr_en_i && wr_mask_i[b]) begin
        mem_q[wr_addr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/mem_endpoint_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_endpoint_top #(
  parameter int els_p = 48
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  mem_pkg::mem_req_t  req_i,
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output mem_pkg::mem_resp_t resp_o
);
  import mem_pkg::*;

  localparam int addr_width_p = $clog2(els_p);

  logic                    stage_valid;
  logic                    stage_ready;
  mem_req_t                stage_req;
  logic                    stage_err;
  logic                    rd_en;
  logic [addr_width_p-1:0] rd_addr;
  logic [data_width_c-1:0] rd_data;
  logic                    wr_en;
  logic [addr_width_p-1:0] wr_addr;
  logic [data_width_c-1:0] wr_data;
  logic [mask_width_c-1:0] wr_mask;
  logic [1:0]              free_slots;
  logic                    push_valid;
  mem_resp_t               push_resp;

  mem_req_stage #(
    .els_p(els_p)
  ) u_req_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .stage_valid_o(stage_valid),
    .stage_ready_i(stage_ready),
    .stage_req_o  (stage_req),
    .stage_err_o  (stage_err)
  );

  mem_access_stage #(
    .addr_width_p(addr_width_p)
  ) u_access_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stage_valid_i(stage_valid),
    .stage_ready_o(stage_ready),
    .stage_req_i  (stage_req),
    .stage_err_i  (stage_err),
    .rd_en_o      (rd_en),
    .rd_addr_o    (rd_addr),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .wr_mask_o    (wr_mask),
    .rd_data_i    (rd_data),
    .free_slots_i (free_slots),
    .push_valid_o (push_valid),
    .push_resp_o  (push_resp)
  );

  mem_byte_array #(
    .els_p       (els_p),
    .addr_width_p(addr_width_p)
  ) u_byte_array (
    .clk_i    (clk_i),
    .rd_en_i  (rd_en),
    .rd_addr_i(rd_addr),
    .rd_data_o(rd_data),
    .wr_en_i  (wr_en),
    .wr_addr_i(wr_addr),
    .wr_data_i(wr_data),
    .wr_mask_i(wr_mask)
  );

  mem_resp_buffer u_resp_buffer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_valid_i(push_valid),
    .push_resp_i (push_resp),
    .free_slots_o(free_slots),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_o      (resp_o)
  );

endmodule

`default_nettype wire

// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int data_width_c       = 32;
  localparam int mask_width_c       = data_width_c / 8;
  localparam int tag_width_c        = 8;
  localparam int addr_field_width_c = 16;
  localparam int pad_width_c        = data_width_c + mask_width_c - tag_width_c;

  typedef enum logic {
    mem_op_read  = 1'b0,
    mem_op_write = 1'b1
  } mem_op_e;

  typedef enum logic {
    mem_status_ok  = 1'b0,
    mem_status_err = 1'b1
  } mem_status_e;

  typedef struct packed {
    logic [data_width_c-1:0] data;
    logic [mask_width_c-1:0] mask;  // One bit per byte lane.
  } wr_payload_t;

  typedef struct packed {
    logic [tag_width_c-1:0] tag;
    logic [pad_width_c-1:0] pad;
  } rd_payload_t;

  // Which view is live depends on the op field of the request.
  typedef union packed {
    wr_payload_t wr;
    rd_payload_t rd;
  } mem_payload_u;

  typedef struct packed {
    mem_op_e                       op;
    logic [addr_field_width_c-1:0] addr;  // Word address.
    mem_payload_u                  payload;
  } mem_req_t;

  typedef struct packed {
    mem_op_e                 op;
    mem_status_e             status;
    logic [tag_width_c-1:0]  tag;   // Zero unless a good read.
    logic [data_width_c-1:0] data;  // Zero unless a good read.
  } mem_resp_t;

endpackage

`default_nettype wire

// File: rtl/mem_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_req_stage #(
  parameter int els_p = 48
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  mem_pkg::mem_req_t req_i,
  output logic              stage_valid_o,
  input  logic              stage_ready_i,
  output mem_pkg::mem_req_t stage_req_o,
  output logic              stage_err_o
);
  import mem_pkg::*;

  logic     init_q;
  logic     full_q;
  logic     err_q;
  logic     accept;
  mem_req_t req_d;
  mem_req_t req_q;

  assign req_ready_o = init_q & (~full_q | stage_ready_i);
  assign accept      = req_valid_i & req_ready_o;

  // Reads carry only a tag, so the rest of the word is cleared.
  always_comb begin
    req_d = req_i;
    if (req_i.op == mem_op_read) begin
      req_d.payload.rd.pad = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      init_q <= 1'b0;
      full_q <= 1'b0;
    end else begin
      init_q <= 1'b1;  // Ready one cycle after reset.
      if (accept) begin
        full_q <= 1'b1;
      end else if (stage_ready_i) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_d;
      err_q <= int'(req_i.addr) >= els_p;  // Range check done once here.
    end
  end

  assign stage_valid_o = full_q;
  assign stage_req_o   = req_q;
  assign stage_err_o   = err_q;

endmodule

`default_nettype wire

// File: rtl/mem_resp_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module mem_resp_buffer (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               push_valid_i,
  input  mem_pkg::mem_resp_t push_resp_i,
  output logic [1:0]         free_slots_o,
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output mem_pkg::mem_resp_t resp_o
);
  import mem_pkg::*;

  mem_resp_t  buf_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       pop;

  assign resp_valid_o = count_q != 2'd0;
  assign resp_o       = buf_q[rd_ptr_q];
  assign pop          = resp_valid_o & resp_ready_i;

  // Slots free at the next edge, so an entry leaving now counts.
  assign free_slots_o = 2'd2 - count_q + {1'b0, pop};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_valid_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push_valid_i} - {1'b0, pop};
    end
  end

  // Pushes only land in a free slot, so the head stays put.
  always_ff @(posedge clk_i) begin
    if (push_valid_i) begin
      buf_q[wr_ptr_q] <= push_resp_i;
    end
  end

endmodule

`default_nettype wire

// File: src.f
rtl/mem_pkg.sv
rtl/mem_byte_array.sv
rtl/mem_req_stage.sv
rtl/mem_access_stage.sv
rtl/mem_resp_buffer.sv
rtl/mem_endpoint_top.sv
tests/mem_endpoint_tb.sv

// File: tests/mem_endpoint_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_endpoint_tb;
  import mem_pkg::*;

  localparam int els_c       = 48;
  localparam int span_c      = 64;  // Includes the out-of-range words.
  localparam int masked_c    = 32;
  localparam int bp_reqs_c   = 200;
  localparam int burst_c     = 64;
  localparam int planned_c   = 4 * els_c + masked_c + 2 * (span_c - els_c) + bp_reqs_c + burst_c;
  localparam int watchdog_c  = 20 * planned_c + 200;

  logic      clk_i;
  logic      rst_i;
  logic      req_valid_i;
  logic      req_ready_o;
  mem_req_t  req_i;
  logic      resp_valid_o;
  logic      resp_ready_i;
  mem_resp_t resp_o;

  logic [data_width_c-1:0] shadow [els_c];  // Unknown until written.
  mem_resp_t exp_q [$];
  int        acc_cyc_q [$];
  int        cyc;
  int        since_rst;
  logic      bp_mode;
  logic      lat_check;
  logic      burst_mode;

  mem_endpoint_top #(.els_p(els_c)) DUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_o      (resp_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic report_failure(string what);
    $display("Error at %0t: %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // Applies a request to the shadow memory and returns its expected response.
  function automatic mem_resp_t model_request(mem_req_t r);
    mem_resp_t e;
    e = '0;
    e.op = r.op;
    if (int'(r.addr) >= els_c) begin
      e.status = mem_status_err;
    end else if (r.op == mem_op_read) begin
      e.tag  = r.payload.rd.tag;
      e.data = shadow[r.addr];
    end else begin
      for (int b = 0; b < mask_width_c; b++) begin
        if (r.payload.wr.mask[b]) shadow[r.addr][b*8 +: 8] = r.payload.wr.data[b*8 +: 8];
      end
    end
    return e;
  endfunction

  function automatic mem_req_t write_req(int addr, logic [31:0] data, logic [3:0] mask);
    mem_req_t r;
    r = '0;
    r.op              = mem_op_write;
    r.addr            = 16'(addr);
    r.payload.wr.data = data;
    r.payload.wr.mask = mask;
    return r;
  endfunction

  function automatic mem_req_t read_req(int addr, logic [7:0] tag);
    mem_req_t r;
    r = '0;
    r.op             = mem_op_read;
    r.addr           = 16'(addr);
    r.payload.rd.tag = tag;
    return r;
  endfunction

  function automatic mem_req_t random_req();
    int addr;
    addr = $urandom % span_c;
    if ($urandom % 2) begin
      return write_req(addr, $urandom, 4'($urandom));
    end else begin
      return read_req(addr, 8'($urandom));
    end
  endfunction

  // Holds valid until the request is taken.
  task automatic send_req(mem_req_t r);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i       = r;
    do @(posedge clk_i); while (!req_ready_o);
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (exp_q.size() != 0) @(posedge clk_i);
  endtask

  always @(negedge clk_i) begin
    if (bp_mode) resp_ready_i = 1'($urandom % 2);
    else resp_ready_i = 1'b1;
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o))
    else report_failure("response changed or vanished while stalled");

  always @(posedge clk_i) begin : monitor
    mem_resp_t exp;
    int        lat;
    if (rst_i) begin
      since_rst = 0;
      if (cyc > 0) begin
        assert (!req_ready_o) else report_mismatch("req_ready_o", 0, req_ready_o);
        assert (!resp_valid_o) else report_mismatch("resp_valid_o", 0, resp_valid_o);
      end
    end else begin
      if (since_rst < 3) begin
        assert (!resp_valid_o) else report_mismatch("resp_valid_o", 0, resp_valid_o);
      end
      if (since_rst == 0) begin
        assert (!req_ready_o) else report_mismatch("req_ready_o", 0, req_ready_o);
      end
      if (since_rst == 1) begin
        assert (req_ready_o) else report_mismatch("req_ready_o", 1, req_ready_o);
      end
      if (burst_mode && req_valid_i) begin
        assert (req_ready_o) else report_failure("req_ready_o dropped in back-to-back burst");
      end
      if (req_valid_i && req_ready_o) begin
        exp_q.push_back(model_request(req_i));
        acc_cyc_q.push_back(cyc);
      end
      if (resp_valid_o && resp_ready_i) begin
        assert (exp_q.size() > 0) else report_failure("response with no request outstanding");
        exp = exp_q.pop_front();
        lat = cyc - acc_cyc_q.pop_front();
        assert (resp_o.op === exp.op) else report_mismatch("resp_o.op", exp.op, resp_o.op);
        assert (resp_o.status === exp.status)
          else report_mismatch("resp_o.status", exp.status, resp_o.status);
        assert (resp_o.tag === exp.tag) else report_mismatch("resp_o.tag", exp.tag, resp_o.tag);
        assert (resp_o.data === exp.data)
          else report_mismatch("resp_o.data", exp.data, resp_o.data);
        if (lat_check) begin
          assert (lat == 3) else report_mismatch("response latency", 3, lat);
        end
      end
      since_rst++;
    end
    cyc++;
  end

  initial begin
    void'($urandom(32'h1537380f));
    clk_i = 1'b0;
    rst_i = 1'b1;
    req_valid_i = 1'b0;
    req_i = '0;
    resp_ready_i = 1'b1;
    bp_mode = 1'b0;
    lat_check = 1'b1;
    burst_mode = 1'b0;
    cyc = 0;
    since_rst = 0;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    repeat (3) @(negedge clk_i);
    for (int a = 0; a < els_c; a++) send_req(write_req(a, $urandom, 4'hf));
    for (int a = 0; a < els_c; a++) send_req(read_req(a, 8'($urandom)));
    for (int i = 0; i < masked_c; i++) send_req(write_req($urandom % els_c, $urandom, 4'($urandom)));
    for (int a = 0; a < els_c; a++) send_req(read_req(a, 8'($urandom)));
    for (int a = els_c; a < span_c; a++) begin
      send_req(write_req(a, $urandom, 4'hf));
      send_req(read_req(a, 8'($urandom)));
    end
    for (int a = 0; a < els_c; a++) send_req(read_req(a, 8'($urandom)));
    wait_drain();
    bp_mode = 1'b1;
    lat_check = 1'b0;
    for (int i = 0; i < bp_reqs_c; i++) send_req(random_req());
    wait_drain();
    bp_mode = 1'b0;
    repeat (2) @(negedge clk_i);
    lat_check = 1'b1;
    burst_mode = 1'b1;
    for (int i = 0; i < burst_c; i++) send_req(random_req());
    wait_drain();
    burst_mode = 1'b0;
    $display("*** PASSED ***");
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_c) @(posedge clk_i);
    report_failure("watchdog expired before all requests completed");
  end

endmodule

`default_nettype wire
